// ==== yolo_pkg.sv ====
package yolo_pkg;

   // sizes
   localparam int ADDR_W     = 8;
   localparam int DATA_W     = 32;
   localparam int DATABUS_W  = 256;
   localparam int DATAPATH_W = 16;
   localparam int ACC_W      = 32;
   localparam int N_LANES    = 4;
   localparam int N_MACS     = 2;
   localparam int REG_IDX_W  = 2;

   // cpu address map
   localparam int CTRL_BIT = 7;
   localparam int CMD_BIT  = 6;
   localparam int UNIT_BIT = 6;

   localparam logic [REG_IDX_W-1:0] REG_RD_BASE = 2'd0;
   localparam logic [REG_IDX_W-1:0] REG_RD_LEN  = 2'd1;
   localparam logic [REG_IDX_W-1:0] REG_WR_BASE = 2'd0;

   // bytes of the write word that carry lane results
   localparam int RES_BYTES = N_LANES * ACC_W / 8;
   localparam logic [DATABUS_W/8-1:0] WR_STRB =
      {{(DATABUS_W/8 - RES_BYTES){1'b0}}, {RES_BYTES{1'b1}}};

   // beat layout
   localparam int BIAS_BITS = N_LANES * DATAPATH_W;
   localparam int MAC_BITS  = N_LANES * N_MACS * DATAPATH_W + N_MACS * DATAPATH_W;

   // register write towards one unit
   typedef struct packed {
      logic                 valid;
      logic [REG_IDX_W-1:0] idx;
      logic [DATA_W-1:0]    data;
   } cfg_wr_t;

   // first beat of a job, one bias per lane
   typedef struct packed {
      logic [DATABUS_W-BIAS_BITS-1:0]     rsvd;
      logic [N_LANES-1:0][DATAPATH_W-1:0] bias;
   } bias_beat_t;

   // following beats, weights lane-major then the shared activations
   typedef struct packed {
      logic [DATABUS_W-MAC_BITS-1:0]                  rsvd;
      logic [N_MACS-1:0][DATAPATH_W-1:0]              act;
      logic [N_LANES-1:0][N_MACS-1:0][DATAPATH_W-1:0] weight;
   } mac_beat_t;

   // one read word, decoded by beat position
   typedef union packed {
      bias_beat_t bias;
      mac_beat_t  mac;
   } rd_word_u;

   // work item for one lane
   typedef struct packed {
      logic                              valid;
      logic                              first;
      logic                              last;
      logic signed [DATAPATH_W-1:0]      bias;
      logic [N_MACS-1:0][DATAPATH_W-1:0] weight;
      logic [N_MACS-1:0][DATAPATH_W-1:0] act;
   } lane_flow_t;

endpackage

// ==== cfg_split.sv ====
`timescale 1ns/1ps

module cfg_split import yolo_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              valid,
   input  logic [ADDR_W-1:0] addr,
   input  logic [DATA_W-1:0] wdata,
   output cfg_wr_t           rd_cfg,
   output cfg_wr_t           wr_cfg,
   output logic              run,
   output logic              clear
);

   logic                 is_ctrl;
   logic                 is_reg;
   logic                 run_req;
   logic                 clear_req;
   logic                 run_r0;
   logic                 run_r1;
   logic                 rd_wr_q;
   logic                 wr_wr_q;
   logic [REG_IDX_W-1:0] idx_q;
   logic [DATA_W-1:0]    data_q;

   // address decode
   assign is_ctrl   = valid & addr[CTRL_BIT];
   assign is_reg    = valid & ~addr[CTRL_BIT];
   assign run_req   = is_ctrl & ~addr[CMD_BIT];
   assign clear_req = is_ctrl & addr[CMD_BIT];

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         run_r0  <= 1'b0;
         run_r1  <= 1'b0;
         run     <= 1'b0;
         clear   <= 1'b0;
         rd_wr_q <= 1'b0;
         wr_wr_q <= 1'b0;
      end else begin
         run_r0  <= run_req;
         run_r1  <= run_r0;
         // one cycle wide even if the cpu repeats the write
         run     <= run_r0 & ~run_r1;
         clear   <= clear_req;
         rd_wr_q <= is_reg & ~addr[UNIT_BIT];
         wr_wr_q <= is_reg & addr[UNIT_BIT];
      end
   end

   // register index and value, shared by both units
   always_ff @(posedge clk) begin
      if (is_reg) begin
         idx_q  <= addr[REG_IDX_W-1:0];
         data_q <= wdata;
      end
   end

   assign rd_cfg = '{valid: rd_wr_q, idx: idx_q, data: data_q};
   assign wr_cfg = '{valid: wr_wr_q, idx: idx_q, data: data_q};

endmodule

// ==== vec_read.sv ====
`timescale 1ns/1ps

module vec_read import yolo_pkg::*; (
   input  logic                     clk,
   input  logic                     rst,
   input  cfg_wr_t                  cfg,
   input  logic                     run,
   input  logic                     clear,
   input  logic                     rd_ready,
   input  rd_word_u                 rd_rdata,
   output logic                     rd_valid,
   output logic [DATA_W-1:0]        rd_addr,
   output lane_flow_t [N_LANES-1:0] flow,
   output logic                     read_done
);

   logic [DATA_W-1:0]                  base_q;
   logic [DATA_W-1:0]                  len_q;
   logic [DATA_W-1:0]                  beat_cnt;
   logic                               accept;
   logic                               is_bias;
   logic                               is_last;
   logic                               valid_q;
   logic                               first_q;
   logic                               last_q;
   logic [N_LANES-1:0][DATAPATH_W-1:0] bias_q;
   mac_beat_t                          mac_q;

   assign accept  = rd_valid & rd_ready;
   assign is_bias = (beat_cnt == '0);
   assign is_last = (beat_cnt == len_q);

   // configuration registers
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         base_q <= '0;
         len_q  <= '0;
      end else if (cfg.valid) begin
         if (cfg.idx == REG_RD_BASE) begin
            base_q <= cfg.data;
         end
         if (cfg.idx == REG_RD_LEN) begin
            len_q <= cfg.data;
         end
      end
   end

   // read sequencer, bias beat then len mac beats
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         rd_valid  <= 1'b0;
         rd_addr   <= '0;
         beat_cnt  <= '0;
         read_done <= 1'b0;
      end else if (run) begin
         rd_valid  <= 1'b1;
         rd_addr   <= base_q;
         beat_cnt  <= '0;
         read_done <= 1'b0;
      end else begin
         if (clear) begin
            read_done <= 1'b0;
         end
         if (accept) begin
            if (is_last) begin
               rd_valid  <= 1'b0;
               read_done <= 1'b1;
            end else begin
               rd_addr  <= rd_addr + 1'b1;
               beat_cnt <= beat_cnt + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= accept;
      end
   end

   // beat decode through the union
   always_ff @(posedge clk) begin
      if (accept) begin
         if (is_bias) begin
            bias_q <= rd_rdata.bias.bias;
            // no products on the bias beat, a zero len job ends here
            mac_q   <= '0;
            first_q <= is_last;
         end else begin
            mac_q   <= rd_rdata.mac;
            first_q <= (beat_cnt == DATA_W'(1));
         end
         last_q <= is_last;
      end
   end

   // fan out to the lanes
   always_comb begin
      for (int k = 0; k < N_LANES; k++) begin
         flow[k].valid  = valid_q;
         flow[k].first  = first_q;
         flow[k].last   = last_q;
         flow[k].bias   = bias_q[k];
         flow[k].weight = mac_q.weight[k];
         flow[k].act    = mac_q.act;
      end
   end

endmodule

// ==== mac_lane.sv ====
`timescale 1ns/1ps

module mac_lane import yolo_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   input  lane_flow_t       flow,
   output logic [ACC_W-1:0] result,
   output logic             res_valid
);

   logic signed [2*DATAPATH_W-1:0] prod [N_MACS];
   logic signed [ACC_W-1:0]        prod_sum;
   logic signed [ACC_W-1:0]        acc_base;
   logic signed [ACC_W-1:0]        acc_q;

   // signed 16x16 products
   always_comb begin
      for (int m = 0; m < N_MACS; m++) begin
         prod[m] = $signed(flow.weight[m]) * $signed(flow.act[m]);
      end
   end

   // adder tree over the products
   always_comb begin
      prod_sum = '0;
      for (int m = 0; m < N_MACS; m++) begin
         prod_sum = prod_sum + ACC_W'(prod[m]);
      end
   end

   // restart from the bias on the first item
   assign acc_base = flow.first ? ACC_W'(flow.bias) : acc_q;

   // wraps at 32 bits
   always_ff @(posedge clk) begin
      if (flow.valid) begin
         acc_q <= acc_base + prod_sum;
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         res_valid <= 1'b0;
      end else begin
         res_valid <= flow.valid & flow.last;
      end
   end

   assign result = acc_q;

endmodule

// ==== vec_write.sv ====
`timescale 1ns/1ps

module vec_write import yolo_pkg::*; (
   input  logic                          clk,
   input  logic                          rst,
   input  cfg_wr_t                       cfg,
   input  logic                          run,
   input  logic                          clear,
   input  logic [N_LANES-1:0][ACC_W-1:0] lane_result,
   input  logic [N_LANES-1:0]            lane_valid,
   input  logic                          wr_ready,
   output logic                          wr_valid,
   output logic [DATA_W-1:0]             wr_addr,
   output logic [DATABUS_W-1:0]          wr_wdata,
   output logic [DATABUS_W/8-1:0]        wr_wstrb,
   output logic                          write_done
);

   logic [DATA_W-1:0] base_q;
   logic              all_valid;

   // lanes run in lockstep, but wait for every one anyway
   assign all_valid = &lane_valid;

   // write base register
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         base_q <= '0;
      end else if (cfg.valid && cfg.idx == REG_WR_BASE) begin
         base_q <= cfg.data;
      end
   end

   // write sequencer and done flag
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         wr_valid   <= 1'b0;
         write_done <= 1'b0;
      end else begin
         if (run || clear) begin
            write_done <= 1'b0;
         end
         if (all_valid) begin
            wr_valid <= 1'b1;
         end else if (wr_valid && wr_ready) begin
            wr_valid   <= 1'b0;
            write_done <= 1'b1;
         end
      end
   end

   // lane k lands in bits 32k+31:32k
   always_ff @(posedge clk) begin
      if (all_valid) begin
         wr_wdata <= DATABUS_W'(lane_result);
      end
   end

   assign wr_addr  = base_q;
   assign wr_wstrb = WR_STRB;

endmodule

// ==== yolo_accel.sv ====
`timescale 1ns/1ps

module yolo_accel import yolo_pkg::*; (
   input  logic                   clk,
   input  logic                   rst,

   // cpu port
   input  logic                   valid,
   input  logic [ADDR_W-1:0]      addr,
   input  logic [DATA_W-1:0]      wdata,
   input  logic [DATA_W/8-1:0]    wstrb,
   output logic                   ready,
   output logic [DATA_W-1:0]      rdata,

   // read databus
   output logic                   rd_valid,
   output logic [DATA_W-1:0]      rd_addr,
   input  logic                   rd_ready,
   input  logic [DATABUS_W-1:0]   rd_rdata,

   // write databus
   output logic                   wr_valid,
   output logic [DATA_W-1:0]      wr_addr,
   output logic [DATABUS_W-1:0]   wr_wdata,
   output logic [DATABUS_W/8-1:0] wr_wstrb,
   input  logic                   wr_ready
);

   logic                          cpu_wr;
   cfg_wr_t                       rd_cfg;
   cfg_wr_t                       wr_cfg;
   logic                          run;
   logic                          clear;
   logic                          read_done;
   logic                          write_done;
   lane_flow_t [N_LANES-1:0]      flow;
   logic [N_LANES-1:0][ACC_W-1:0] lane_result;
   logic [N_LANES-1:0]            lane_valid;

   // writes without strobes are dropped
   assign cpu_wr = valid & (|wstrb);

   // only the done bit is readable
   assign ready = 1'b1;
   assign rdata = {{(DATA_W-1){1'b0}}, read_done & write_done};

   cfg_split cfg_split (
      .clk   (clk),
      .rst   (rst),
      .valid (cpu_wr),
      .addr  (addr),
      .wdata (wdata),
      .rd_cfg(rd_cfg),
      .wr_cfg(wr_cfg),
      .run   (run),
      .clear (clear)
   );

   vec_read vec_read (
      .clk      (clk),
      .rst      (rst),
      .cfg      (rd_cfg),
      .run      (run),
      .clear    (clear),
      .rd_ready (rd_ready),
      .rd_rdata (rd_rdata),
      .rd_valid (rd_valid),
      .rd_addr  (rd_addr),
      .flow     (flow),
      .read_done(read_done)
   );

   // one accumulator per lane
   for (genvar k = 0; k < N_LANES; k++) begin : g_lane
      mac_lane mac_lane (
         .clk      (clk),
         .rst      (rst),
         .flow     (flow[k]),
         .result   (lane_result[k]),
         .res_valid(lane_valid[k])
      );
   end

   vec_write vec_write (
      .clk        (clk),
      .rst        (rst),
      .cfg        (wr_cfg),
      .run        (run),
      .clear      (clear),
      .lane_result(lane_result),
      .lane_valid (lane_valid),
      .wr_ready   (wr_ready),
      .wr_valid   (wr_valid),
      .wr_addr    (wr_addr),
      .wr_wdata   (wr_wdata),
      .wr_wstrb   (wr_wstrb),
      .write_done (write_done)
   );

endmodule

// ==== tb_yolo_ref.svh ====
`ifndef TB_YOLO_REF_SVH
`define TB_YOLO_REF_SVH

// one bias beat, built through the read word union
function automatic logic [DATABUS_W-1:0] bias_beat(
   input logic [N_LANES-1:0][DATAPATH_W-1:0] bias
);
   rd_word_u w;
   w = '0;
   w.bias.bias = bias;
   return w;
endfunction

// one mac beat, weights per lane plus the shared activations
function automatic logic [DATABUS_W-1:0] mac_beat(
   input logic [N_LANES-1:0][N_MACS-1:0][DATAPATH_W-1:0] weight,
   input logic [N_MACS-1:0][DATAPATH_W-1:0]              act
);
   rd_word_u w;
   w = '0;
   w.mac.weight = weight;
   w.mac.act    = act;
   return w;
endfunction

// random operand, or only the two signed extremes
function automatic logic [DATAPATH_W-1:0] pick_value(input bit extreme);
   logic [31:0] r;
   r = $random(seed);
   if (extreme) begin
      return r[0] ? 16'h8000 : 16'h7fff;
   end
   return r[DATAPATH_W-1:0];
endfunction

// expected write word from the memory contents
function automatic logic [DATABUS_W-1:0] ref_result(input int base, input int len);
   logic [DATABUS_W-1:0]         res;
   logic [DATABUS_W-1:0]         word;
   logic signed [DATAPATH_W-1:0] bias;
   logic signed [DATAPATH_W-1:0] wt;
   logic signed [DATAPATH_W-1:0] act;
   logic signed [ACC_W-1:0]      acc;
   res = '0;
   for (int k = 0; k < N_LANES; k++) begin
      bias = mem[base][DATAPATH_W*k +: DATAPATH_W];
      acc  = bias;
      for (int i = 1; i <= len; i++) begin
         word = mem[base + i];
         for (int m = 0; m < N_MACS; m++) begin
            wt  = word[2*DATAPATH_W*k + DATAPATH_W*m +: DATAPATH_W];
            act = word[128 + DATAPATH_W*m +: DATAPATH_W];
            // 32 bit context, so the sum wraps like the lanes
            acc = acc + wt * act;
         end
      end
      res[ACC_W*k +: ACC_W] = acc;
   end
   return res;
endfunction

`endif

// ==== tb_yolo_accel.sv ====
`timescale 1ns/1ps

module tb_yolo_accel import yolo_pkg::*; ();

   localparam int                     TIMEOUT      = 1000;
   localparam logic [ADDR_W-1:0]      RD_BASE_ADDR = 8'h00;
   localparam logic [ADDR_W-1:0]      RD_LEN_ADDR  = 8'h01;
   localparam logic [ADDR_W-1:0]      WR_BASE_ADDR = 8'h40;
   localparam logic [ADDR_W-1:0]      RUN_ADDR     = 8'h80;
   localparam logic [ADDR_W-1:0]      CLEAR_ADDR   = 8'hc0;
   localparam logic [DATABUS_W/8-1:0] EXP_STRB     = 32'h0000_ffff;

   logic                   clk;
   logic                   rst;
   logic                   valid;
   logic [ADDR_W-1:0]      addr;
   logic [DATA_W-1:0]      wdata;
   logic [DATA_W/8-1:0]    wstrb;
   logic                   ready;
   logic [DATA_W-1:0]      rdata;
   logic                   rd_valid;
   logic [DATA_W-1:0]      rd_addr;
   logic                   rd_ready;
   logic [DATABUS_W-1:0]   rd_rdata;
   logic                   wr_valid;
   logic [DATA_W-1:0]      wr_addr;
   logic [DATABUS_W-1:0]   wr_wdata;
   logic [DATABUS_W/8-1:0] wr_wstrb;
   logic                   wr_ready;

   integer                 seed = 32'h265ecb4e;
   int                     errors = 0;
   int                     checked = 0;
   int                     jobs = 0;
   logic [DATABUS_W-1:0]   mem [256];
   logic [DATA_W-1:0]      read_log [$];
   logic [DATABUS_W-1:0]   exp_data_q [$];
   logic [DATA_W-1:0]      exp_addr_q [$];
   string                  name_q [$];
   logic [DATABUS_W-1:0]   got_data_q [$];
   logic [DATA_W-1:0]      got_addr_q [$];
   logic [DATABUS_W/8-1:0] got_strb_q [$];

   `include "tb_yolo_ref.svh"

   yolo_accel DUT (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // read memory, ready after 0 to 3 idle cycles
   initial begin : read_responder
      int wait_n;
      bit took;
      rd_ready = 1'b0;
      rd_rdata = '0;
      wait_n   = $random(seed) & 3;
      forever begin
         @(posedge clk);
         took = rd_valid && rd_ready;
         if (took) begin
            read_log.push_back(rd_addr);
         end
         #5;
         if (took) begin
            rd_ready = 1'b0;
            wait_n   = $random(seed) & 3;
         end
         if (rd_valid && !rd_ready) begin
            if (wait_n == 0) begin
               rd_ready = 1'b1;
               rd_rdata = mem[rd_addr[7:0]];
            end else begin
               wait_n--;
            end
         end
      end
   end

   // write side, records every accepted transfer
   initial begin : write_monitor
      int wait_n;
      bit took;
      wr_ready = 1'b0;
      wait_n   = $random(seed) & 3;
      forever begin
         @(posedge clk);
         took = wr_valid && wr_ready;
         if (took) begin
            got_data_q.push_back(wr_wdata);
            got_addr_q.push_back(wr_addr);
            got_strb_q.push_back(wr_wstrb);
         end
         #5;
         if (took) begin
            wr_ready = 1'b0;
            wait_n   = $random(seed) & 3;
         end
         if (wr_valid && !wr_ready) begin
            if (wait_n == 0) begin
               wr_ready = 1'b1;
            end else begin
               wait_n--;
            end
         end
      end
   end

   initial begin : compare_writes
      logic [DATABUS_W-1:0]   exp_data;
      logic [DATABUS_W-1:0]   got_data;
      logic [DATA_W-1:0]      exp_addr;
      logic [DATA_W-1:0]      got_addr;
      logic [DATABUS_W/8-1:0] got_strb;
      string                  name;
      forever begin
         @(posedge clk);
         #1;
         if (got_data_q.size() > 0) begin
            got_data = got_data_q.pop_front();
            got_addr = got_addr_q.pop_front();
            got_strb = got_strb_q.pop_front();
            if (exp_data_q.size() == 0) begin
               errors++;
               $display("write to address %h arrived with no job pending", got_addr);
            end else begin
               exp_data = exp_data_q.pop_front();
               exp_addr = exp_addr_q.pop_front();
               name     = name_q.pop_front();
               // upper words are expected as zero
               for (int k = 0; k < DATABUS_W/32; k++) begin
                  if (got_data[32*k +: 32] !== exp_data[32*k +: 32]) begin
                     errors++;
                     $display("ERR %s: word %0d expected %h actual %h", name, k,
                              exp_data[32*k +: 32], got_data[32*k +: 32]);
                  end
               end
               if (got_addr !== exp_addr) begin
                  errors++;
                  $display("ERR %s: address expected %h actual %h", name, exp_addr, got_addr);
               end
               if (got_strb !== EXP_STRB) begin
                  errors++;
                  $display("ERR %s: strobe expected %h actual %h", name, EXP_STRB, got_strb);
               end
               checked++;
            end
         end
      end
   end

   task automatic cpu_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      @(posedge clk);
      #5;
      valid = 1'b1;
      addr  = a;
      wdata = d;
      wstrb = '1;
      // cpu port never stalls
      if (ready !== 1'b1) begin
         errors++;
         $display("ERR cpu_port: ready expected 1 actual %b", ready);
      end
      @(posedge clk);
      #5;
      valid = 1'b0;
      wstrb = '0;
   endtask

   task automatic wait_done(input string name, input bit level);
      int n;
      n = 0;
      while (rdata !== DATA_W'(level) && n < TIMEOUT) begin
         @(posedge clk);
         #5;
         n++;
      end
      if (rdata !== DATA_W'(level)) begin
         errors++;
         $display("%s: status word never read %0d within %0d cycles", name, level, TIMEOUT);
      end
   endtask

   task automatic wait_checked(input string name, input int target);
      int n;
      n = 0;
      while (checked < target && n < TIMEOUT) begin
         @(posedge clk);
         #5;
         n++;
      end
      if (checked < target) begin
         errors++;
         $display("%s: no result write was seen within %0d cycles", name, TIMEOUT);
      end
   endtask

   task automatic check_reads(input string name, input int rbase, input int len);
      if (read_log.size() != len + 1) begin
         errors++;
         $display("ERR %s: read count expected %0d actual %0d", name, len + 1, read_log.size());
      end else begin
         for (int i = 0; i <= len; i++) begin
            if (read_log[i] !== DATA_W'(rbase + i)) begin
               errors++;
               $display("ERR %s: read %0d address expected %h actual %h", name, i,
                        DATA_W'(rbase + i), read_log[i]);
            end
         end
      end
   endtask

   task automatic fill_job(input int base, input int len, input bit extreme);
      logic [N_LANES-1:0][DATAPATH_W-1:0]             b;
      logic [N_LANES-1:0][N_MACS-1:0][DATAPATH_W-1:0] w;
      logic [N_MACS-1:0][DATAPATH_W-1:0]              a;
      for (int k = 0; k < N_LANES; k++) begin
         b[k] = pick_value(extreme);
      end
      mem[base] = bias_beat(b);
      for (int i = 1; i <= len; i++) begin
         for (int k = 0; k < N_LANES; k++) begin
            for (int m = 0; m < N_MACS; m++) begin
               w[k][m] = pick_value(extreme);
            end
         end
         for (int m = 0; m < N_MACS; m++) begin
            a[m] = pick_value(extreme);
         end
         mem[base + i] = mac_beat(w, a);
      end
   endtask

   task automatic run_job(input string name, input int rbase, input int len,
                          input logic [DATA_W-1:0] wbase);
      cpu_write(RD_BASE_ADDR, rbase);
      cpu_write(RD_LEN_ADDR, len);
      cpu_write(WR_BASE_ADDR, wbase);
      exp_data_q.push_back(ref_result(rbase, len));
      exp_addr_q.push_back(wbase);
      name_q.push_back(name);
      jobs++;
      read_log.delete();
      cpu_write(RUN_ADDR, 32'h0);
      // done from the previous job drops on the run pulse
      wait_done(name, 1'b0);
      wait_done(name, 1'b1);
      wait_checked(name, jobs);
      check_reads(name, rbase, len);
   endtask

   initial begin
      rst   = 1'b1;
      valid = 1'b0;
      addr  = '0;
      wdata = '0;
      wstrb = '0;
      for (int a = 0; a < 256; a++) begin
         mem[a] = {8{32'hc0de_0000 ^ a}};
      end
      repeat (10) @(posedge clk);
      #5;
      rst = 1'b0;

      if (rdata !== DATA_W'(0)) begin
         errors++;
         $display("ERR done_clear: rdata before job expected %h actual %h", DATA_W'(0), rdata);
      end

      fill_job(16, 3, 1'b0);
      run_job("basic", 16, 3, 32'h0000_1000);

      fill_job(40, 0, 1'b0);
      run_job("bias_only", 40, 0, 32'h0000_2000);

      fill_job(60, 8, 1'b1);
      run_job("signed_wrap", 60, 8, 32'h0000_3000);

      fill_job(100, 12, 1'b0);
      run_job("back_pressure", 100, 12, 32'h0000_4000);

      if (rdata !== DATA_W'(1)) begin
         errors++;
         $display("ERR done_clear: rdata after job expected %h actual %h", DATA_W'(1), rdata);
      end
      cpu_write(CLEAR_ADDR, 32'h0);
      wait_done("done_clear", 1'b0);
      fill_job(140, 5, 1'b0);
      run_job("done_clear", 140, 5, 32'h0000_5000);

      $display("%0d errors over %0d checked writes", errors, checked);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+.
yolo_pkg.sv
cfg_split.sv
vec_read.sv
mac_lane.sv
vec_write.sv
yolo_accel.sv
tb_yolo_accel.sv
